/* verilog/testerPkg.sv */
//####################################################################
// shared constants for the block cipher tester: bus widths,
// mailbox word layout, status bits and XTEA constants
//####################################################################
package testerPkg;

  // bus and memory widths
  localparam int PLB_ADDR_W  = 32;
  localparam int PLB_DATA_W  = 64;
  localparam int BRAM_IDX_W  = 14;
  localparam int BRAM_DATA_W = 32;
  localparam int KEY_W       = 128;
  // block count field, low half of MB_COUNT and high half of status
  localparam int COUNT_W     = 16;

  // mailbox word indices
  localparam logic [BRAM_IDX_W-1:0] MB_CMD    = 14'd0;
  localparam logic [BRAM_IDX_W-1:0] MB_SRC    = 14'd1;
  localparam logic [BRAM_IDX_W-1:0] MB_DST    = 14'd2;
  localparam logic [BRAM_IDX_W-1:0] MB_COUNT  = 14'd3;
  // key word 0 is the most significant
  localparam logic [BRAM_IDX_W-1:0] MB_KEY0   = 14'd4;
  localparam logic [BRAM_IDX_W-1:0] MB_KEY1   = 14'd5;
  localparam logic [BRAM_IDX_W-1:0] MB_KEY2   = 14'd6;
  localparam logic [BRAM_IDX_W-1:0] MB_KEY3   = 14'd7;
  localparam logic [BRAM_IDX_W-1:0] MB_STATUS = 14'd8;

  // status word bit positions
  localparam int STAT_DONE = 0;
  localparam int STAT_ERR  = 1;

  // xtea
  localparam logic [31:0] XTEA_DELTA  = 32'h9E3779B9;
  localparam int          XTEA_CYCLES = 32;

  // single double-word transfers
  localparam logic [7:0]            PLB_BE_ALL  = 8'hFF;
  localparam logic [PLB_ADDR_W-1:0] BLOCK_BYTES = 32'd8;

endpackage

/* verilog/plbMasterIf.sv */
//####################################################################
// single-beat request/response link, controller to PLB master
//####################################################################
`timescale 1ns/1ps

interface plbMasterIf;

  // request side, addr and wrData stay put until done
  logic                            req;
  logic                            rnw;
  logic [testerPkg::PLB_ADDR_W-1:0] addr;
  logic [testerPkg::PLB_DATA_W-1:0] wrData;

  // response side, err and rdData qualified by done
  logic                            done;
  logic                            err;
  logic [testerPkg::PLB_DATA_W-1:0] rdData;

  modport ctrl (output req, rnw, addr, wrData,
                input  done, err, rdData);

  modport master (input  req, rnw, addr, wrData,
                  output done, err, rdData);

endinterface

/* verilog/cipherIf.sv */
//####################################################################
// start/done link between controller and XTEA engine
//####################################################################
`timescale 1ns/1ps

interface cipherIf;

  // block and key sampled on start
  logic                            start;
  logic [testerPkg::PLB_DATA_W-1:0] block;
  logic [testerPkg::KEY_W-1:0]      key;

  // result holds until the next start
  logic                            busy;
  logic                            done;
  logic [testerPkg::PLB_DATA_W-1:0] result;

  modport ctrl   (output start, block, key, input busy, done, result);
  modport engine (input start, block, key, output busy, done, result);

endinterface

/* verilog/plbMaster.sv */
//####################################################################
// PLB master for single-beat reads and writes, one per request
//####################################################################
`timescale 1ns/1ps

module plbMaster (
  input  logic                             CLK,
  input  logic                             rst,
  plbMasterIf.master                       bus,
  output logic [testerPkg::PLB_ADDR_W-1:0] mABus,
  output logic [7:0]                       mBE,
  output logic                             mRNW,
  output logic                             mRequest,
  output logic [3:0]                       mSize,
  output logic [testerPkg::PLB_DATA_W-1:0] mWrDBus,
  input  logic                             mAddrAck,
  input  logic                             mRdDAck,
  input  logic [testerPkg::PLB_DATA_W-1:0] mRdDBus,
  input  logic                             mWrDAck,
  input  logic                             mErr
);

  typedef enum logic [1:0] {IDLE, ADDR_PH, DATA_PH} masterStateT;

  masterStateT                      state;
  logic                             rnwQ;
  logic [testerPkg::PLB_ADDR_W-1:0] addrQ;
  logic [testerPkg::PLB_DATA_W-1:0] wrDataQ;
  logic                             dataAck;

  // address phase lasts until the slave takes the address
  assign mRequest = (state == ADDR_PH);
  assign mABus    = addrQ;
  assign mRNW     = mRequest & rnwQ;
  assign mBE      = mRequest ? testerPkg::PLB_BE_ALL : 8'h00;
  // single beat only
  assign mSize    = 4'b0000;
  assign mWrDBus  = wrDataQ;

  // ack that matches the direction in flight
  assign dataAck = rnwQ ? mRdDAck : mWrDAck;

  always_ff @(posedge CLK) begin
    if (rst) begin
      state    <= IDLE;
      bus.done <= 1'b0;
      bus.err  <= 1'b0;
    end else begin
      bus.done <= 1'b0;
      case (state)
        IDLE: begin
          if (bus.req) state <= ADDR_PH;
        end
        ADDR_PH: begin
          // an error ends the transfer wherever it lands
          if (mErr) begin
            state    <= IDLE;
            bus.done <= 1'b1;
            bus.err  <= 1'b1;
          end else if (mAddrAck) begin
            state <= DATA_PH;
          end
        end
        DATA_PH: begin
          if (mErr || dataAck) begin
            state    <= IDLE;
            bus.done <= 1'b1;
            bus.err  <= mErr;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // request fields and read data
  always_ff @(posedge CLK) begin
    if (state == IDLE && bus.req) begin
      rnwQ    <= bus.rnw;
      addrQ   <= bus.addr;
      wrDataQ <= bus.wrData;
    end
    if (state == DATA_PH && rnwQ && mRdDAck) bus.rdData <= mRdDBus;
  end

endmodule

/* verilog/xteaCipher.sv */
//####################################################################
// iterative XTEA encryption, one full Feistel cycle per clock
//####################################################################
`timescale 1ns/1ps

module xteaCipher (
  input  logic     CLK,
  input  logic     rst,
  cipherIf.engine  cph
);

  logic [31:0]                          v0;
  logic [31:0]                          v1;
  logic [31:0]                          sum;
  logic [testerPkg::KEY_W-1:0]          keyQ;
  logic [$clog2(testerPkg::XTEA_CYCLES)-1:0] roundCnt;
  logic [31:0]                          v0Next;
  logic [31:0]                          v1Next;
  logic [31:0]                          sumNext;

  // key word 0 sits in the top 32 bits
  function automatic logic [31:0] keyWord(input logic [testerPkg::KEY_W-1:0] k,
                                          input logic [1:0] idx);
    keyWord = k[(3 - idx) * 32 +: 32];
  endfunction

  // both half-rounds of one cycle
  always_comb begin
    sumNext = sum + testerPkg::XTEA_DELTA;
    v0Next  = v0 + ((((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum + keyWord(keyQ, sum[1:0])));
    // second half uses the advanced sum, bits 12:11 pick the key
    v1Next  = v1 + ((((v0Next << 4) ^ (v0Next >> 5)) + v0Next) ^
                    (sumNext + keyWord(keyQ, sumNext[12:11])));
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      cph.busy <= 1'b0;
      cph.done <= 1'b0;
      roundCnt <= '0;
    end else begin
      cph.done <= 1'b0;
      if (cph.start) begin
        cph.busy <= 1'b1;
        roundCnt <= '0;
      end else if (cph.busy) begin
        roundCnt <= roundCnt + 1'b1;
        // last cycle, result ready next clock
        if (roundCnt == testerPkg::XTEA_CYCLES - 1) begin
          cph.busy <= 1'b0;
          cph.done <= 1'b1;
        end
      end
    end
  end

  // datapath
  always_ff @(posedge CLK) begin
    if (cph.start) begin
      v0   <= cph.block[63:32];
      v1   <= cph.block[31:0];
      sum  <= '0;
      keyQ <= cph.key;
    end else if (cph.busy) begin
      v0  <= v0Next;
      v1  <= v1Next;
      sum <= sumNext;
    end
  end

  assign cph.result = {v0, v1};

endmodule

/* verilog/testerControl.sv */
//####################################################################
// mailbox poller and job sequencer: BRAM mailbox, PLB reads and
// writes, cipher runs and the final status word
//####################################################################
`timescale 1ns/1ps

module testerControl (
  input  logic                                CLK,
  input  logic                                rst,
  output logic [testerPkg::BRAM_IDX_W-1:0]    bramIdx,
  output logic [testerPkg::BRAM_DATA_W-1:0]   bramDout,
  output logic [testerPkg::BRAM_DATA_W/8-1:0] bramWEN,
  output logic                                bramEN,
  input  logic [testerPkg::BRAM_DATA_W-1:0]   bramDin,
  plbMasterIf.ctrl                            plb,
  cipherIf.ctrl                               cph
);

  typedef enum logic [3:0] {
    IDLE, POLL_RD, POLL_CHK, LOAD_RD, LOAD_CAP, ACK_WR, RD_REQ,
    RD_WAIT, CIPH_GO, CIPH_WAIT, WR_REQ, WR_WAIT, STATUS_WR
  } ctrlStateT;

  ctrlStateT                          state;
  logic [testerPkg::BRAM_IDX_W-1:0]  wordIdx;
  logic [testerPkg::PLB_ADDR_W-1:0]  srcQ;
  logic [testerPkg::PLB_ADDR_W-1:0]  dstQ;
  logic [testerPkg::COUNT_W-1:0]     remaining;
  logic [testerPkg::COUNT_W-1:0]     doneCnt;
  logic                              errFlag;
  logic [testerPkg::KEY_W-1:0]       keyQ;
  logic [testerPkg::BRAM_DATA_W-1:0] statusWord;

  always_comb begin
    statusWord                        = '0;
    statusWord[testerPkg::STAT_DONE]  = 1'b1;
    statusWord[testerPkg::STAT_ERR]   = errFlag;
    statusWord[testerPkg::BRAM_DATA_W-1 -: testerPkg::COUNT_W] = doneCnt;
  end

  // BRAM port, reads and writes by state
  always_comb begin
    bramEN   = 1'b0;
    bramWEN  = '0;
    bramIdx  = testerPkg::MB_CMD;
    bramDout = '0;
    case (state)
      POLL_RD: bramEN = 1'b1;
      LOAD_RD: begin
        bramEN  = 1'b1;
        bramIdx = wordIdx;
      end
      // clearing go tells the processor the job was taken
      ACK_WR: begin
        bramEN  = 1'b1;
        bramWEN = '1;
      end
      STATUS_WR: begin
        bramEN   = 1'b1;
        bramWEN  = '1;
        bramIdx  = testerPkg::MB_STATUS;
        bramDout = statusWord;
      end
      default: ;
    endcase
  end

  // PLB and cipher requests
  assign plb.req    = (state == RD_REQ) || (state == WR_REQ);
  assign plb.rnw    = (state == RD_REQ) || (state == RD_WAIT);
  assign plb.addr   = plb.rnw ? srcQ : dstQ;
  assign plb.wrData = cph.result;
  assign cph.start  = (state == CIPH_GO) && !cph.busy;
  assign cph.block  = plb.rdData;
  assign cph.key    = keyQ;

  always_ff @(posedge CLK) begin
    if (rst) begin
      state   <= IDLE;
      errFlag <= 1'b0;
      doneCnt <= '0;
    end else begin
      case (state)
        IDLE:     state <= POLL_RD;
        POLL_RD:  state <= POLL_CHK;
        POLL_CHK: begin
          if (bramDin[0]) begin
            state   <= LOAD_RD;
            errFlag <= 1'b0;
            doneCnt <= '0;
          end else begin
            state <= POLL_RD;
          end
        end
        LOAD_RD:  state <= LOAD_CAP;
        LOAD_CAP: state <= (wordIdx == testerPkg::MB_KEY3) ? ACK_WR : LOAD_RD;
        // zero blocks goes straight to status
        ACK_WR:   state <= (remaining == '0) ? STATUS_WR : RD_REQ;
        RD_REQ:   state <= RD_WAIT;
        RD_WAIT: begin
          if (plb.done && plb.err) begin
            errFlag <= 1'b1;
            state   <= STATUS_WR;
          end else if (plb.done) begin
            state <= CIPH_GO;
          end
        end
        CIPH_GO:   if (!cph.busy) state <= CIPH_WAIT;
        CIPH_WAIT: if (cph.done) state <= WR_REQ;
        WR_REQ:    state <= WR_WAIT;
        WR_WAIT: begin
          if (plb.done && plb.err) begin
            errFlag <= 1'b1;
            state   <= STATUS_WR;
          end else if (plb.done) begin
            doneCnt <= doneCnt + 1'b1;
            state   <= (remaining == 1) ? STATUS_WR : RD_REQ;
          end
        end
        STATUS_WR: state <= IDLE;
        default:   state <= IDLE;
      endcase
    end
  end

  // job registers
  always_ff @(posedge CLK) begin
    if (state == POLL_CHK) wordIdx <= testerPkg::MB_SRC;
    if (state == LOAD_CAP) begin
      wordIdx <= wordIdx + 1'b1;
      case (wordIdx)
        testerPkg::MB_SRC:   srcQ      <= bramDin;
        testerPkg::MB_DST:   dstQ      <= bramDin;
        testerPkg::MB_COUNT: remaining <= bramDin[testerPkg::COUNT_W-1:0];
        // most significant key word arrives first
        testerPkg::MB_KEY0, testerPkg::MB_KEY1,
        testerPkg::MB_KEY2, testerPkg::MB_KEY3:
          keyQ <= {keyQ[testerPkg::KEY_W-testerPkg::BRAM_DATA_W-1:0], bramDin};
        default: ;
      endcase
    end
    // step both pointers after each good write
    if (state == WR_WAIT && plb.done && !plb.err) begin
      srcQ      <= srcQ + testerPkg::BLOCK_BYTES;
      dstQ      <= dstQ + testerPkg::BLOCK_BYTES;
      remaining <= remaining - 1'b1;
    end
  end

endmodule

/* verilog/blockCipherTester.sv */
//####################################################################
// block cipher tester top: PLB master, XTEA engine, controller
//####################################################################
`timescale 1ns/1ps

module blockCipherTester (
  input  logic                                CLK,
  input  logic                                rst,
  output logic [testerPkg::PLB_ADDR_W-1:0]    plbMasterWires_mABus,
  output logic [7:0]                          plbMasterWires_mBE,
  output logic                                plbMasterWires_mRNW,
  output logic                                plbMasterWires_mRequest,
  output logic [3:0]                          plbMasterWires_mSize,
  output logic [testerPkg::PLB_DATA_W-1:0]    plbMasterWires_mWrDBus,
  input  logic                                plbMasterWires_mAddrAck,
  input  logic                                plbMasterWires_mRdDAck,
  input  logic [testerPkg::PLB_DATA_W-1:0]    plbMasterWires_mRdDBus,
  input  logic                                plbMasterWires_mWrDAck,
  input  logic                                plbMasterWires_mErr,
  output logic [testerPkg::BRAM_DATA_W-1:0]   bramInitiatorWires_bramAddr,
  output logic [testerPkg::BRAM_DATA_W-1:0]   bramInitiatorWires_bramDout,
  output logic [testerPkg::BRAM_DATA_W/8-1:0] bramInitiatorWires_bramWEN,
  output logic                                bramInitiatorWires_bramEN,
  input  logic [testerPkg::BRAM_DATA_W-1:0]   bramInitiatorWires_bramDin
);

  logic [testerPkg::BRAM_IDX_W-1:0] bramIdx;

  plbMasterIf plbBus ();
  cipherIf    cphBus ();

  // word index to byte address, upper bits zero
  assign bramInitiatorWires_bramAddr =
    {{(testerPkg::BRAM_DATA_W - testerPkg::BRAM_IDX_W - 2){1'b0}}, bramIdx, 2'b00};

  plbMaster uMaster (
    .CLK      (CLK),
    .rst      (rst),
    .bus      (plbBus.master),
    .mABus    (plbMasterWires_mABus),
    .mBE      (plbMasterWires_mBE),
    .mRNW     (plbMasterWires_mRNW),
    .mRequest (plbMasterWires_mRequest),
    .mSize    (plbMasterWires_mSize),
    .mWrDBus  (plbMasterWires_mWrDBus),
    .mAddrAck (plbMasterWires_mAddrAck),
    .mRdDAck  (plbMasterWires_mRdDAck),
    .mRdDBus  (plbMasterWires_mRdDBus),
    .mWrDAck  (plbMasterWires_mWrDAck),
    .mErr     (plbMasterWires_mErr)
  );

  xteaCipher uCipher (
    .CLK (CLK),
    .rst (rst),
    .cph (cphBus.engine)
  );

  testerControl uControl (
    .CLK      (CLK),
    .rst      (rst),
    .bramIdx  (bramIdx),
    .bramDout (bramInitiatorWires_bramDout),
    .bramWEN  (bramInitiatorWires_bramWEN),
    .bramEN   (bramInitiatorWires_bramEN),
    .bramDin  (bramInitiatorWires_bramDin),
    .plb      (plbBus.ctrl),
    .cph      (cphBus.ctrl)
  );

endmodule

/* bench/tbModels.sv */
//####################################################################
// testbench models: PLB slave memory with random ack delays and
// error injection, 16-word BRAM mailbox
//####################################################################
`timescale 1ns/1ps

module plbSlaveMem (
  input  logic        CLK,
  input  logic        rst,
  input  logic [31:0] mABus,
  input  logic        mRNW,
  input  logic        mRequest,
  input  logic [63:0] mWrDBus,
  input  logic [1:0]  ackDelay,
  input  logic        errArmed,
  input  logic [31:0] errAddr,
  output logic        mAddrAck,
  output logic        mRdDAck,
  output logic [63:0] mRdDBus,
  output logic        mWrDAck,
  output logic        mErr
);

  logic [63:0] mem [logic [31:0]];
  logic [1:0]  phase;
  logic [1:0]  waitCnt;
  logic [31:0] addrQ;
  logic        rnwQ;

  // unwritten words read back as a pattern of their full address
  function automatic logic [63:0] peek(input logic [31:0] a);
    peek = mem.exists(a) ? mem[a] : {~a, a};
  endfunction

  function automatic bit holds(input logic [31:0] a);
    holds = mem.exists(a);
  endfunction

  task automatic poke(input logic [31:0] a, input logic [63:0] d);
    mem[a] = d;
  endtask

  initial begin
    mAddrAck = 1'b0;
    mRdDAck  = 1'b0;
    mRdDBus  = '0;
    mWrDAck  = 1'b0;
    mErr     = 1'b0;
  end

  // phases: 0 idle, 1 ack delay, 2 data beat, 3 turnaround
  always @(posedge CLK) begin
    mAddrAck <= 1'b0;
    mRdDAck  <= 1'b0;
    mWrDAck  <= 1'b0;
    mErr     <= 1'b0;
    if (rst) begin
      phase <= 2'd0;
    end else begin
      case (phase)
        2'd0: begin
          if (mRequest) begin
            addrQ   <= mABus;
            rnwQ    <= mRNW;
            waitCnt <= ackDelay;
            phase   <= 2'd1;
          end
        end
        2'd1: begin
          if (waitCnt != 2'd0) begin
            waitCnt <= waitCnt - 2'd1;
          end else if (errArmed && addrQ == errAddr) begin
            // armed address gets an error instead of an ack
            mErr  <= 1'b1;
            phase <= 2'd3;
          end else begin
            mAddrAck <= 1'b1;
            phase    <= 2'd2;
          end
        end
        2'd2: begin
          if (rnwQ) begin
            mRdDAck <= 1'b1;
            mRdDBus <= peek(addrQ);
          end else begin
            mWrDAck    <= 1'b1;
            mem[addrQ] = mWrDBus;
          end
          phase <= 2'd3;
        end
        default: phase <= 2'd0;
      endcase
    end
  end

endmodule

module bramMailbox (
  input  logic        CLK,
  input  logic [31:0] addr,
  input  logic [31:0] din,
  input  logic [3:0]  wen,
  input  logic        en,
  output logic [31:0] dout
);

  logic [31:0] mem [16];

  initial begin
    dout = '0;
    for (int i = 0; i < 16; i++) mem[i] = '0;
  end

  // read-first, data one cycle after enable
  always @(posedge CLK) begin
    if (en) begin
      if (wen != 4'h0) mem[addr[5:2]] <= din;
      dout <= mem[addr[5:2]];
    end
  end

  // processor side access between jobs
  task automatic put(input int idx, input logic [31:0] val);
    mem[idx] <= val;
  endtask

  function automatic logic [31:0] get(input int idx);
    get = mem[idx];
  endfunction

endmodule

/* bench/tbTop.sv */
//####################################################################
// testbench top with clock, reset, mailbox jobs, XTEA reference,
// assertions, per-test reporting and timeout
//####################################################################
`timescale 1ns/1ps

module tbTop;

  logic        CLK;
  logic        rst;
  logic [31:0] mABus;
  logic [7:0]  mBE;
  logic        mRNW;
  logic        mRequest;
  logic [3:0]  mSize;
  logic [63:0] mWrDBus;
  logic        mAddrAck;
  logic        mRdDAck;
  logic [63:0] mRdDBus;
  logic        mWrDAck;
  logic        mErr;
  logic [31:0] bramAddr;
  logic [31:0] bramDout;
  logic [3:0]  bramWEN;
  logic        bramEN;
  logic [31:0] bramDin;
  logic [1:0]  ackDelay;
  logic        errArmed;
  logic [31:0] errAddr;
  logic        jobActive;
  logic        zeroJob;
  logic [31:0] stimLfsr;
  logic [31:0] delayLfsr;
  int          fails = 0;
  int          tests = 0;
  int          cycles = 0;
  // 6 jobs of 8 blocks at 60 cycles per block plus margin
  int          timeoutCycles = 6 * 8 * 60 + 400;

  blockCipherTester dut (
    .CLK                         (CLK),
    .rst                         (rst),
    .plbMasterWires_mABus        (mABus),
    .plbMasterWires_mBE          (mBE),
    .plbMasterWires_mRNW         (mRNW),
    .plbMasterWires_mRequest     (mRequest),
    .plbMasterWires_mSize        (mSize),
    .plbMasterWires_mWrDBus      (mWrDBus),
    .plbMasterWires_mAddrAck     (mAddrAck),
    .plbMasterWires_mRdDAck      (mRdDAck),
    .plbMasterWires_mRdDBus      (mRdDBus),
    .plbMasterWires_mWrDAck      (mWrDAck),
    .plbMasterWires_mErr         (mErr),
    .bramInitiatorWires_bramAddr (bramAddr),
    .bramInitiatorWires_bramDout (bramDout),
    .bramInitiatorWires_bramWEN  (bramWEN),
    .bramInitiatorWires_bramEN   (bramEN),
    .bramInitiatorWires_bramDin  (bramDin)
  );

  plbSlaveMem slave (
    .CLK (CLK), .rst (rst), .mABus (mABus), .mRNW (mRNW), .mRequest (mRequest),
    .mWrDBus (mWrDBus), .ackDelay (ackDelay), .errArmed (errArmed),
    .errAddr (errAddr), .mAddrAck (mAddrAck), .mRdDAck (mRdDAck),
    .mRdDBus (mRdDBus), .mWrDAck (mWrDAck), .mErr (mErr)
  );

  bramMailbox mbox (
    .CLK (CLK), .addr (bramAddr), .din (bramDout), .wen (bramWEN),
    .en (bramEN), .dout (bramDin)
  );

  always #50 CLK = ~CLK;

  // one step of a 32-bit Galois LFSR
  function automatic logic [31:0] galoisStep(input logic [31:0] s);
    galoisStep = s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
  endfunction

  function automatic logic [63:0] randBits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r        = {r[62:0], stimLfsr[0]};
      stimLfsr = galoisStep(stimLfsr);
    end
    return r;
  endfunction

  // XTEA encryption with key word 0 most significant
  function automatic logic [63:0] xteaRef(input logic [63:0] pt, input logic [127:0] key);
    logic [31:0] v0;
    logic [31:0] v1;
    logic [31:0] sum;
    logic [31:0] k [4];
    v0  = pt[63:32];
    v1  = pt[31:0];
    sum = '0;
    for (int j = 0; j < 4; j++) k[j] = key[127 - 32 * j -: 32];
    for (int r = 0; r < 32; r++) begin
      v0  = v0 + ((((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum + k[sum[1:0]]));
      sum = sum + 32'h9E3779B9;
      v1  = v1 + ((((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum + k[sum[12:11]]));
    end
    return {v0, v1};
  endfunction

  task automatic logFailure(input string msg);
    fails++;
    $display("[FAIL] %0t %s", $time, msg);
  endtask

  task automatic testDone(input string name, input int failsBefore);
    tests++;
    $display("test %0d %s: %s", tests, name, (fails == failsBefore) ? "ok" : "errors");
  endtask

  // two delay bits per cycle for the slave
  always @(posedge CLK) begin : delayDraw
    logic [31:0] midState;
    midState  = galoisStep(delayLfsr);
    ackDelay  <= {midState[0], delayLfsr[0]};
    delayLfsr <= galoisStep(midState);
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles > timeoutCycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  // address phase held until the slave takes it
  assert property (@(posedge CLK) disable iff (rst)
    mRequest && !mAddrAck && !mErr |=> mRequest && $stable(mABus))
    else logFailure("mRequest or mABus changed before mAddrAck");

  // every request is a single beat with all bytes enabled
  assert property (@(posedge CLK) disable iff (rst)
    mRequest |-> mBE == 8'hFF && mSize == 4'h0)
    else logFailure("mBE or mSize wrong during a PLB request");

  // quiet bus and mailbox while go is clear
  assert property (@(posedge CLK) disable iff (rst)
    !jobActive |-> !mRequest && bramWEN == 4'h0)
    else logFailure("PLB request or BRAM write with no job pending");

  assert property (@(posedge CLK) disable iff (rst) zeroJob |-> !mRequest)
    else logFailure("PLB request during a zero-block job");

  assert property (@(posedge CLK) disable iff (rst) bramWEN == 4'h0 || bramWEN == 4'hF)
    else logFailure("partial BRAM byte enables");

  // fill the mailbox, set go, wait for the status write
  task automatic runJob(input logic [31:0] src, input logic [31:0] dst,
                        input logic [15:0] count, input logic [127:0] key);
    @(posedge CLK);
    jobActive = 1'b1;
    mbox.put(testerPkg::MB_SRC, src);
    mbox.put(testerPkg::MB_DST, dst);
    mbox.put(testerPkg::MB_COUNT, {16'h0, count});
    mbox.put(testerPkg::MB_KEY0, key[127:96]);
    mbox.put(testerPkg::MB_KEY1, key[95:64]);
    mbox.put(testerPkg::MB_KEY2, key[63:32]);
    mbox.put(testerPkg::MB_KEY3, key[31:0]);
    mbox.put(testerPkg::MB_CMD, 32'h1);
    do @(negedge CLK); while (!(bramEN && bramWEN != 4'h0 && bramAddr == 32'd32));
    @(negedge CLK);
    jobActive = 1'b0;
  endtask

  task automatic checkStatus(input logic expErr, input logic [15:0] expCount);
    logic [31:0] expWord;
    logic [31:0] got;
    expWord = {expCount, 14'd0, expErr, 1'b1};
    got     = mbox.get(testerPkg::MB_STATUS);
    assert (mbox.get(testerPkg::MB_CMD) == 32'h0)
      else logFailure("MB_CMD go not cleared");
    assert (got == expWord)
      else logFailure($sformatf("status %h, expected %h", got, expWord));
  endtask

  task automatic checkBlock(input logic [31:0] dst, input logic [63:0] pt,
                            input logic [127:0] key);
    logic [63:0] expData;
    expData = xteaRef(pt, key);
    assert (slave.peek(dst) === expData)
      else logFailure($sformatf("dst %h holds %h, expected %h", dst, slave.peek(dst), expData));
  endtask

  initial begin
    logic [127:0] key;
    logic [63:0]  pt [5];
    int           mark;
    CLK       = 1'b0;
    rst       = 1'b1;
    errArmed  = 1'b0;
    errAddr   = '0;
    ackDelay  = '0;
    jobActive = 1'b0;
    zeroJob   = 1'b0;
    stimLfsr  = 32'd99798;
    delayLfsr = 32'd99798;
    repeat (3) @(posedge CLK);
    rst <= 1'b0;

    mark = fails;
    repeat (20) @(posedge CLK);
    testDone("idle with go clear", mark);

    mark = fails;
    key   = {randBits(64), randBits(64)};
    pt[0] = randBits(64);
    slave.poke(32'h1000, pt[0]);
    runJob(32'h1000, 32'h2000, 16'd1, key);
    checkBlock(32'h2000, pt[0], key);
    checkStatus(1'b0, 16'd1);
    testDone("single block", mark);

    mark = fails;
    key  = {randBits(64), randBits(64)};
    for (int i = 0; i < 5; i++) begin
      pt[i] = randBits(64);
      slave.poke(32'h3000 + 8 * i, pt[i]);
    end
    runJob(32'h3000, 32'h4000, 16'd5, key);
    for (int i = 0; i < 5; i++) begin
      checkBlock(32'h4000 + 8 * i, pt[i], key);
      assert (slave.peek(32'h3000 + 8 * i) === pt[i])
        else logFailure($sformatf("source word %0d changed", i));
    end
    testDone("five blocks", mark);

    mark = fails;
    checkStatus(1'b0, 16'd5);
    testDone("mailbox after five blocks", mark);

    mark = fails;
    key  = {randBits(64), randBits(64)};
    for (int i = 0; i < 5; i++) begin
      pt[i] = randBits(64);
      slave.poke(32'h5000 + 8 * i, pt[i]);
    end
    // third block's source read hits the error
    @(posedge CLK);
    errAddr  <= 32'h5010;
    errArmed <= 1'b1;
    runJob(32'h5000, 32'h6000, 16'd5, key);
    @(posedge CLK);
    errArmed <= 1'b0;
    checkBlock(32'h6000, pt[0], key);
    checkBlock(32'h6008, pt[1], key);
    for (int i = 2; i < 5; i++) begin
      assert (!slave.holds(32'h6000 + 8 * i))
        else logFailure($sformatf("destination %0d written after the error", i));
    end
    checkStatus(1'b1, 16'd2);
    testDone("bus error on third read", mark);

    mark    = fails;
    zeroJob = 1'b1;
    runJob(32'h7000, 32'h8000, 16'd0, key);
    zeroJob = 1'b0;
    checkStatus(1'b0, 16'd0);
    testDone("zero blocks", mark);

    $display("tests %0d, failed checks %0d", tests, fails);
    if (fails == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
verilog/testerPkg.sv
verilog/plbMasterIf.sv
verilog/cipherIf.sv
verilog/plbMaster.sv
verilog/xteaCipher.sv
verilog/testerControl.sv
verilog/blockCipherTester.sv
bench/tbModels.sv
bench/tbTop.sv
